//--- tb.f
+incdir+verilog
verilog/expipe_pkg.sv
verilog/modn_counter.sv
verilog/op_only_rs.sv
verilog/issue_arbiter.sv
verilog/cdb_arbiter.sv
verilog/expipe_top.sv
tests/expipe_checker.sv
tests/tb_expipe.sv

//--- Makefile
# Verilator flow for the back-end slice

VERILATOR ?= verilator
TOP       ?= tb_expipe
LINT_TOP  ?= expipe_top
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall
PASS_STR  ?= TESTS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

# Pass only when the pass line shows up in the output
run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_STR)"

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(LINT_TOP)

clean:
	rm -rf $(BUILD_DIR)

//--- tests/tb_expipe.sv
// Self-checking testbench for the back-end slice, runs a stimulus table against a scoreboard model
`timescale 1ns/1ps
`include "expipe_defines.svh"

module tb_expipe import expipe_pkg::*; ();

    typedef enum logic [2:0] {K_IDLE, K_ISSUE, K_WB, K_FLUSH, K_READY} step_kind_t;

    // One table row, exp_ready only used by K_READY
    typedef struct packed {
        step_kind_t kind;
        issue_req_t req;
        cdb_data_t  wb;
        logic       exp_ready;
    } step_t;

    // Scoreboard view of one station entry
    typedef struct packed {
        logic     ready;
        rob_idx_t src;
        xlen_t    value;
        rob_idx_t dest;
    } model_ent_t;

    localparam int MAX_STEPS    = 64;
    localparam int DRAIN_CYCLES = 64;

    logic       clk = 1'b0;
    logic       rst_n;
    logic       flush;
    logic       issue_valid;
    logic       issue_ready;
    issue_req_t issue_req;
    logic       ext_wb_valid;
    cdb_data_t  ext_wb;
    logic       cdb_valid;
    cdb_data_t  cdb;

    step_t      steps [MAX_STEPS];
    int         n_steps;
    int         seed;
    int         cycles = 0;
    int         limit = MAX_STEPS * 20 + 200;
    model_ent_t rs_q [`EXPIPE_NUM_RS][$];
    cdb_data_t  wb_pend;
    logic       wb_pend_v = 1'b0;

    expipe_top dut0 (
        .clk_i          (clk),
        .rst_n_i        (rst_n),
        .flush_i        (flush),
        .issue_valid_i  (issue_valid),
        .issue_ready_o  (issue_ready),
        .issue_req_i    (issue_req),
        .ext_wb_valid_i (ext_wb_valid),
        .ext_wb_i       (ext_wb),
        .cdb_valid_o    (cdb_valid),
        .cdb_o          (cdb)
    );

    always #10 clk = ~clk;

    // ----------------------------------------
    // Reporting and compares
    // ----------------------------------------

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_cdb(input cdb_data_t got, input cdb_data_t exp_pkt);
        if (got !== exp_pkt) begin
            fail_run($sformatf(
                "[FAIL] %0t ns: CDB tag %0d value %h exc %b/%h, expected %0d %h %b/%h",
                $time, got.rob_idx, got.value, got.except_raised, got.except_code,
                exp_pkt.rob_idx, exp_pkt.value, exp_pkt.except_raised, exp_pkt.except_code));
        end
    endtask

    task automatic check_ready(input logic got, input logic exp_rdy, input rs_sel_t sel);
        if (got !== exp_rdy) begin
            fail_run($sformatf("[FAIL] %0t ns: issue ready for station %0d is %b, expected %b",
                $time, sel, got, exp_rdy));
        end
    endtask

    // ----------------------------------------
    // Table builders
    // ----------------------------------------

    task automatic issue_entry(input int sel, input logic rdy, input int src, input int dest);
        step_t s;
        s = '0;
        s.kind          = K_ISSUE;
        s.req.rs_sel    = rs_sel_t'(sel);
        s.req.rs1_ready = rdy;
        s.req.rs1_idx   = rob_idx_t'(src);
        s.req.rs1_value = $random(seed);
        s.req.dest_idx  = rob_idx_t'(dest);
        steps[n_steps]  = s;
        n_steps++;
    endtask

    task automatic wb_entry(input int tag, input logic exc);
        step_t s;
        s = '0;
        s.kind             = K_WB;
        s.wb.rob_idx       = rob_idx_t'(tag);
        s.wb.value         = $random(seed);
        s.wb.except_raised = exc;
        s.wb.except_code   = exc ? 4'hd : 4'h0;
        steps[n_steps]     = s;
        n_steps++;
    endtask

    task automatic ready_entry(input int sel, input logic exp_rdy);
        step_t s;
        s = '0;
        s.kind         = K_READY;
        s.req.rs_sel   = rs_sel_t'(sel);
        s.exp_ready    = exp_rdy;
        steps[n_steps] = s;
        n_steps++;
    endtask

    task automatic flush_entry();
        steps[n_steps]      = '0;
        steps[n_steps].kind = K_FLUSH;
        n_steps++;
    endtask

    task automatic idle_entries(input int n);
        for (int i = 0; i < n; i++) begin
            steps[n_steps] = '0;
            n_steps++;
        end
    endtask

    task automatic build_table();
        n_steps = 0;
        // Ready operands over every station
        issue_entry(0, 1'b1, 0, 0);
        issue_entry(1, 1'b1, 0, 1);
        issue_entry(2, 1'b1, 0, 2);
        issue_entry(0, 1'b1, 0, 3);
        idle_entries(4);
        // Waiting head in front of a ready younger entry
        issue_entry(1, 1'b0, 12, 4);
        issue_entry(1, 1'b1, 0, 5);
        idle_entries(3);
        wb_entry(13, 1'b0);
        wb_entry(12, 1'b1);
        idle_entries(4);
        wb_entry(12, 1'b0);
        idle_entries(4);
        // Station 2 full of waiting entries
        issue_entry(2, 1'b0, 14, 6);
        issue_entry(2, 1'b0, 14, 7);
        issue_entry(2, 1'b0, 14, 8);
        issue_entry(2, 1'b0, 14, 9);
        ready_entry(2, 1'b0);
        ready_entry(0, 1'b1);
        // Station 0 waits on the same tag and contends for the CDB
        issue_entry(0, 1'b0, 14, 10);
        wb_entry(14, 1'b0);
        idle_entries(8);
        // Station 0 filled with waiters, then dropped by flush
        issue_entry(0, 1'b0, 15, 11);
        issue_entry(0, 1'b0, 15, 12);
        issue_entry(0, 1'b0, 15, 13);
        issue_entry(0, 1'b0, 15, 14);
        ready_entry(0, 1'b0);
        flush_entry();
        ready_entry(0, 1'b1);
        wb_entry(15, 1'b0);
        idle_entries(4);
        issue_entry(1, 1'b1, 0, 0);
        issue_entry(2, 1'b1, 0, 1);
    endtask

    // ----------------------------------------
    // Driver
    // ----------------------------------------

    // Each step starts 1 ns after a rising edge
    task automatic apply_step(input step_t st);
        logic taken;
        taken = 1'b0;
        case (st.kind)
            K_ISSUE: begin
                issue_req   = st.req;
                issue_valid = 1'b1;
                while (!taken) begin
                    @(negedge clk);
                    taken = issue_ready;
                    @(posedge clk);
                end
                #1;
                issue_valid = 1'b0;
            end
            K_WB: begin
                ext_wb       = st.wb;
                ext_wb_valid = 1'b1;
                @(posedge clk);
                #1;
                ext_wb_valid = 1'b0;
            end
            K_FLUSH: begin
                flush = 1'b1;
                @(posedge clk);
                #1;
                flush = 1'b0;
            end
            K_READY: begin
                issue_req = st.req;
                @(negedge clk);
                check_ready(issue_ready, st.exp_ready, st.req.rs_sel);
                @(posedge clk);
                #1;
            end
            default: begin
                @(posedge clk);
                #1;
            end
        endcase
    endtask

    function automatic int outstanding();
        int n;
        n = int'(wb_pend_v);
        for (int s = 0; s < `EXPIPE_NUM_RS; s++) begin
            n += rs_q[s].size();
        end
        return n;
    endfunction

    // ----------------------------------------
    // Scoreboard, sampled mid-cycle
    // ----------------------------------------

    always @(negedge clk) begin : monitor
        cdb_data_t  exp_pkt;
        model_ent_t ent;
        logic       hit;
        logic       fwd;
        hit = 1'b0;
        if (rst_n) begin
            if (wb_pend_v && !cdb_valid) begin
                fail_run($sformatf("External writeback missing from the CDB at %0t ns", $time));
            end
            if (cdb_valid) begin
                if (wb_pend_v) begin
                    check_cdb(cdb, wb_pend);
                    hit = 1'b1;
                end
                // Only a ready head may leave its station
                for (int s = 0; s < `EXPIPE_NUM_RS; s++) begin
                    if (!hit && rs_q[s].size() > 0 && rs_q[s][0].ready
                        && rs_q[s][0].dest == cdb.rob_idx) begin
                        exp_pkt.rob_idx       = rs_q[s][0].dest;
                        exp_pkt.value         = rs_q[s][0].value;
                        exp_pkt.except_raised = 1'b0;
                        exp_pkt.except_code   = 4'h0;
                        check_cdb(cdb, exp_pkt);
                        void'(rs_q[s].pop_front());
                        hit = 1'b1;
                    end
                end
                if (!hit) begin
                    fail_run($sformatf("Unexpected CDB broadcast of tag %0d at %0t ns",
                        cdb.rob_idx, $time));
                end
                // Clean broadcast wakes every matching waiter
                for (int s = 0; s < `EXPIPE_NUM_RS; s++) begin
                    for (int i = 0; i < rs_q[s].size(); i++) begin
                        ent = rs_q[s][i];
                        if (!cdb.except_raised && !ent.ready && ent.src == cdb.rob_idx) begin
                            ent.ready   = 1'b1;
                            ent.value   = cdb.value;
                            rs_q[s][i]  = ent;
                        end
                    end
                end
            end
            wb_pend_v = 1'b0;
            if (flush) begin
                for (int s = 0; s < `EXPIPE_NUM_RS; s++) begin
                    rs_q[s].delete();
                end
            end else begin
                if (ext_wb_valid) begin
                    wb_pend   = ext_wb;
                    wb_pend_v = 1'b1;
                end
                if (issue_valid && issue_ready) begin
                    fwd = cdb_valid && !cdb.except_raised && !issue_req.rs1_ready
                          && cdb.rob_idx == issue_req.rs1_idx;
                    ent.ready = issue_req.rs1_ready || fwd;
                    ent.src   = issue_req.rs1_idx;
                    ent.value = fwd ? cdb.value : issue_req.rs1_value;
                    ent.dest  = issue_req.dest_idx;
                    rs_q[int'(issue_req.rs_sel)].push_back(ent);
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > limit) begin
            fail_run($sformatf("Timeout: no verdict after %0d cycles", limit));
        end
    end

    initial begin : driver
        int waited;
        seed         = 32'ha97baa65;
        rst_n        = 1'b0;
        flush        = 1'b0;
        issue_valid  = 1'b0;
        issue_req    = '0;
        ext_wb_valid = 1'b0;
        ext_wb       = '0;
        build_table();
        limit = n_steps * 20 + 200;
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        for (int i = 0; i < n_steps; i++) begin
            apply_step(steps[i]);
        end
        // Drain for a bounded time, then watch for stray broadcasts
        waited = 0;
        while (outstanding() != 0 && waited < DRAIN_CYCLES) begin
            @(posedge clk);
            waited++;
        end
        repeat (8) @(posedge clk);
        if (outstanding() == 0) begin
            $display("TESTS PASSED");
            $finish;
        end else begin
            fail_run("Results still outstanding at the end of the run");
        end
    end

endmodule

//--- tests/expipe_checker.sv
// Concurrent assertions bound onto each station and the CDB arbiter, watching handshakes and reset
`timescale 1ns/1ps

module expipe_checker #(
    parameter int N = 1,
    parameter int W = 1
) (
    input logic         clk_i,
    input logic         rst_n_i,
    input logic         flush_i,
    input logic         hs_valid_i,
    input logic         hs_ready_i,
    input logic [W-1:0] hs_data_i,
    input logic [N-1:0] grant_i,
    input logic         out_valid_i
);

    // ----------------------------------------
    // Handshake rules
    // ----------------------------------------

    // At most one source served per cycle
    grant_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $onehot0(grant_i))
        else $error("more than one grant raised in the same cycle");

    // Stalled request held until taken
    stall_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        hs_valid_i && !hs_ready_i && !flush_i |=> $stable(hs_data_i))
        else $error("request changed while stalled");

    // Quiet bus right out of reset
    reset_quiet: assert property (@(posedge clk_i)
        $rose(rst_n_i) |-> !out_valid_i)
        else $error("output valid in the first cycle after reset");

endmodule

bind op_only_rs expipe_checker #(
    .N($bits(rs_ready_i)),
    .W($bits(issue_req_i))
) u_rs_chk (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .flush_i     (flush_i),
    .hs_valid_i  (issue_valid_i),
    .hs_ready_i  (issue_ready_o),
    .hs_data_i   (issue_req_i),
    .grant_i     (rs_ready_i),
    .out_valid_i (rs_valid_o)
);

// Station 0 drain handshake stands in for the request side
bind cdb_arbiter expipe_checker #(
    .N($bits(rs_ready_o)),
    .W($bits(ext_wb_i))
) u_cdb_chk (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .flush_i     (flush_i),
    .hs_valid_i  (rs_valid_i[0]),
    .hs_ready_i  (rs_ready_o[0]),
    .hs_data_i   (rs_data_i[0]),
    .grant_i     (rs_ready_o),
    .out_valid_i (cdb_valid_o)
);

//--- verilog/expipe_top.sv
// Top level of the back-end slice, wiring the issue arbiter, the station array and the CDB arbiter
`timescale 1ns/1ps
`include "expipe_defines.svh"

module expipe_top import expipe_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_n_i,
    input  logic       flush_i,

    // Issue port
    input  logic       issue_valid_i,
    output logic       issue_ready_o,
    input  issue_req_t issue_req_i,

    // External writeback port
    input  logic       ext_wb_valid_i,
    input  cdb_data_t  ext_wb_i,

    // CDB out
    output logic       cdb_valid_o,
    output cdb_data_t  cdb_o
);

    // ----------------------------------------
    // Interconnect
    // ----------------------------------------

    logic [`EXPIPE_NUM_RS-1:0] rs_issue_valid;
    logic [`EXPIPE_NUM_RS-1:0] rs_issue_ready;
    logic [`EXPIPE_NUM_RS-1:0] rs_req_valid;
    logic [`EXPIPE_NUM_RS-1:0] rs_grant;
    cdb_data_t                 rs_result [`EXPIPE_NUM_RS];

    issue_arbiter u_issue_arb (
        .issue_valid_i (issue_valid_i),
        .issue_req_i   (issue_req_i),
        .issue_ready_o (issue_ready_o),
        .rs_valid_o    (rs_issue_valid),
        .rs_ready_i    (rs_issue_ready)
    );

    // Same request fans out, only the steered valid differs
    for (genvar g = 0; g < `EXPIPE_NUM_RS; g++) begin : gen_rs
        op_only_rs u_rs (
            .clk_i         (clk_i),
            .rst_n_i       (rst_n_i),
            .flush_i       (flush_i),
            .issue_valid_i (rs_issue_valid[g]),
            .issue_ready_o (rs_issue_ready[g]),
            .issue_req_i   (issue_req_i),
            .cdb_valid_i   (cdb_valid_o),
            .cdb_i         (cdb_o),
            .rs_ready_i    (rs_grant[g]),
            .rs_valid_o    (rs_req_valid[g]),
            .rs_data_o     (rs_result[g])
        );
    end

    cdb_arbiter u_cdb_arb (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .flush_i        (flush_i),
        .ext_wb_valid_i (ext_wb_valid_i),
        .ext_wb_i       (ext_wb_i),
        .rs_valid_i     (rs_req_valid),
        .rs_data_i      (rs_result),
        .rs_ready_o     (rs_grant),
        .cdb_valid_o    (cdb_valid_o),
        .cdb_o          (cdb_o)
    );

endmodule

//--- verilog/cdb_arbiter.sv
// Picks one CDB source per cycle from external writeback and the stations, then registers it onto the CDB
`timescale 1ns/1ps
`include "expipe_defines.svh"

module cdb_arbiter import expipe_pkg::*; (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  logic                      flush_i,

    // Other execution units, no back-pressure
    input  logic                      ext_wb_valid_i,
    input  cdb_data_t                 ext_wb_i,

    // Station requests and grants
    input  logic [`EXPIPE_NUM_RS-1:0] rs_valid_i,
    input  cdb_data_t                 rs_data_i [`EXPIPE_NUM_RS],
    output logic [`EXPIPE_NUM_RS-1:0] rs_ready_o,

    // Registered broadcast
    output logic                      cdb_valid_o,
    output cdb_data_t                 cdb_o
);

    rs_sel_t   rr_ptr_q;
    rs_sel_t   win_idx;
    logic      win_found;
    logic      sel_valid;
    cdb_data_t sel_data;

    // ----------------------------------------
    // Round-robin search from the pointer
    // ----------------------------------------

    always_comb begin : rr_pick
        int unsigned idx;
        win_found = 1'b0;
        win_idx   = '0;
        for (int off = 0; off < `EXPIPE_NUM_RS; off++) begin
            idx = (int'(rr_ptr_q) + off) % `EXPIPE_NUM_RS;
            // First requester at or after the pointer
            if (!win_found && rs_valid_i[idx]) begin
                win_found = 1'b1;
                win_idx   = rs_sel_t'(idx);
            end
        end
    end

    // External writeback beats every station
    always_comb begin
        rs_ready_o = '0;
        sel_valid  = 1'b0;
        sel_data   = ext_wb_i;
        if (flush_i) begin
            // Nothing goes out while flushing
            sel_valid = 1'b0;
        end else if (ext_wb_valid_i) begin
            sel_valid = 1'b1;
        end else if (win_found) begin
            rs_ready_o[win_idx] = 1'b1;
            sel_valid           = 1'b1;
            sel_data            = rs_data_i[win_idx];
        end
    end

    // ----------------------------------------
    // Pointer and CDB register
    // ----------------------------------------

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rr_ptr_q    <= '0;
            cdb_valid_o <= 1'b0;
        end else if (flush_i) begin
            rr_ptr_q    <= '0;
            cdb_valid_o <= 1'b0;
        end else begin
            cdb_valid_o <= sel_valid;
            // Step past the station just served
            if (|rs_ready_o) begin
                if (int'(win_idx) == `EXPIPE_NUM_RS - 1) begin
                    rr_ptr_q <= '0;
                end else begin
                    rr_ptr_q <= win_idx + 1'b1;
                end
            end
        end
    end

    // Packet held until the next winner
    always_ff @(posedge clk_i) begin
        if (sel_valid) begin
            cdb_o <= sel_data;
        end
    end

endmodule

//--- verilog/issue_arbiter.sv
// Steers the single issue port to the station named in the request and returns that station's ready
`timescale 1ns/1ps
`include "expipe_defines.svh"

module issue_arbiter import expipe_pkg::*; (
    // Front end handshake
    input  logic                      issue_valid_i,
    input  issue_req_t                issue_req_i,
    output logic                      issue_ready_o,

    // Per-station handshake
    output logic [`EXPIPE_NUM_RS-1:0] rs_valid_o,
    input  logic [`EXPIPE_NUM_RS-1:0] rs_ready_i
);

    // ----------------------------------------
    // Selector decode
    // ----------------------------------------

    rs_sel_t sel;
    logic    sel_ok;

    assign sel = issue_req_i.rs_sel;

    // Codes past the last station go nowhere
    assign sel_ok = (int'(sel) < `EXPIPE_NUM_RS);

    always_comb begin
        // Nothing raised by default
        rs_valid_o    = '0;
        issue_ready_o = 1'b0;

        if (sel_ok) begin
            // Only the addressed station sees valid
            rs_valid_o[sel] = issue_valid_i;
            // Ready comes back from that same station
            issue_ready_o   = rs_ready_i[sel];
        end
    end

endmodule

//--- verilog/op_only_rs.sv
// Operand-only reservation station, one per generate slot, holding instructions until their operand is known
`timescale 1ns/1ps
`include "expipe_defines.svh"

module op_only_rs import expipe_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_n_i,
    input  logic       flush_i,

    // Issue side
    input  logic       issue_valid_i,
    output logic       issue_ready_o,
    input  issue_req_t issue_req_i,

    // Wakeup bus
    input  logic       cdb_valid_i,
    input  cdb_data_t  cdb_i,

    // Drain side, ready is the CDB grant
    input  logic       rs_ready_i,
    output logic       rs_valid_o,
    output cdb_data_t  rs_data_o
);

    localparam int PTR_W = $clog2(`EXPIPE_RS_DEPTH);

    // Payload part of an entry
    typedef struct packed {
        rob_idx_t rs1_idx;
        xlen_t    rs1_value;
        rob_idx_t dest_idx;
    } rs_entry_t;

    // ----------------------------------------
    // Storage
    // ----------------------------------------

    rs_entry_t entries [`EXPIPE_RS_DEPTH];

    // Status bits per entry
    logic [`EXPIPE_RS_DEPTH-1:0] valid_q;
    logic [`EXPIPE_RS_DEPTH-1:0] op_ready_q;

    // FIFO pointers
    logic [PTR_W-1:0] head_idx;
    logic [PTR_W-1:0] tail_idx;

    logic push;
    logic pop;

    // Per-entry tag match on the CDB
    logic [`EXPIPE_RS_DEPTH-1:0] wake;

    // Operand arrives on the CDB in the same cycle as its consumer
    logic push_fwd;

    // Clean broadcast, exception results never wake anyone
    logic cdb_clean;

    // ----------------------------------------
    // Handshake and control
    // ----------------------------------------

    // Room only while the tail slot is free
    assign issue_ready_o = !valid_q[tail_idx] && !flush_i;
    assign push          = issue_valid_i && issue_ready_o;

    // Head leaves only with its operand in hand
    assign rs_valid_o = valid_q[head_idx] && op_ready_q[head_idx];
    assign pop        = rs_valid_o && rs_ready_i && !flush_i;

    assign cdb_clean = cdb_valid_i && !cdb_i.except_raised;

    always_comb begin
        for (int i = 0; i < `EXPIPE_RS_DEPTH; i++) begin
            wake[i] = cdb_clean && valid_q[i] && !op_ready_q[i]
                      && (entries[i].rs1_idx == cdb_i.rob_idx);
        end
    end

    assign push_fwd = cdb_clean && !issue_req_i.rs1_ready
                      && (issue_req_i.rs1_idx == cdb_i.rob_idx);

    // ----------------------------------------
    // Status update
    // ----------------------------------------

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q    <= '0;
            op_ready_q <= '0;
        end else if (flush_i) begin
            valid_q    <= '0;
            op_ready_q <= '0;
        end else begin
            // Wakeups first, push and pop touch other slots
            for (int i = 0; i < `EXPIPE_RS_DEPTH; i++) begin
                if (wake[i]) begin
                    op_ready_q[i] <= 1'b1;
                end
            end
            if (pop) begin
                valid_q[head_idx] <= 1'b0;
            end
            if (push) begin
                valid_q[tail_idx]    <= 1'b1;
                op_ready_q[tail_idx] <= issue_req_i.rs1_ready || push_fwd;
            end
        end
    end

    // Payload, valid bits qualify it
    always_ff @(posedge clk_i) begin
        for (int i = 0; i < `EXPIPE_RS_DEPTH; i++) begin
            if (wake[i]) begin
                entries[i].rs1_value <= cdb_i.value;
            end
        end
        if (push) begin
            entries[tail_idx].rs1_idx   <= issue_req_i.rs1_idx;
            entries[tail_idx].dest_idx  <= issue_req_i.dest_idx;
            // Take the broadcast value when it beats the entry in
            entries[tail_idx].rs1_value <= push_fwd ? cdb_i.value : issue_req_i.rs1_value;
        end
    end

    // ----------------------------------------
    // Pointers
    // ----------------------------------------

    modn_counter #(
        .N(`EXPIPE_RS_DEPTH)
    ) u_head_cnt (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .en_i    (pop),
        .clr_i   (flush_i),
        .count_o (head_idx)
    );

    modn_counter #(
        .N(`EXPIPE_RS_DEPTH)
    ) u_tail_cnt (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .en_i    (push),
        .clr_i   (flush_i),
        .count_o (tail_idx)
    );

    // Result is the operand itself, tagged with the head's destination
    assign rs_data_o.rob_idx       = entries[head_idx].dest_idx;
    assign rs_data_o.value         = entries[head_idx].rs1_value;
    assign rs_data_o.except_raised = 1'b0;
    assign rs_data_o.except_code   = 4'h0;

endmodule

//--- verilog/modn_counter.sv
// Wrap-around counter modulo N with synchronous clear, instantiated for the station FIFO pointers
`timescale 1ns/1ps

module modn_counter #(
    parameter int N = 4
) (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 en_i,
    input  logic                 clr_i,
    output logic [$clog2(N)-1:0] count_o
);

    localparam int CNT_W = $clog2(N);

    // Terminal value before the wrap
    localparam logic [CNT_W-1:0] LAST = CNT_W'(N - 1);

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            count_o <= '0;
        end else if (clr_i) begin
            // Clear wins over enable
            count_o <= '0;
        end else if (en_i) begin
            if (count_o == LAST) begin
                count_o <= '0;
            end else begin
                count_o <= count_o + 1'b1;
            end
        end
    end

endmodule

//--- verilog/expipe_pkg.sv
// Shared data types for the back end, imported by every RTL module that carries issue or CDB data
`include "expipe_defines.svh"

package expipe_pkg;

    // ----------------------------------------
    // Plain vector types
    // ----------------------------------------

    // Operand or result value
    typedef logic [`EXPIPE_XLEN-1:0] xlen_t;

    // ROB entry tag
    typedef logic [`EXPIPE_ROB_IDX_W-1:0] rob_idx_t;

    // Station number used to steer an issue
    // Values at or above EXPIPE_NUM_RS are not decoded
    typedef logic [$clog2(`EXPIPE_NUM_RS)-1:0] rs_sel_t;

    // ----------------------------------------
    // Bus packets
    // ----------------------------------------

    // One CDB broadcast
    typedef struct packed {
        // Tag of the producing instruction
        rob_idx_t   rob_idx;
        // Result value
        xlen_t      value;
        // Producer hit an exception, consumers must not wake
        logic       except_raised;
        // Passed through untouched
        logic [3:0] except_code;
    } cdb_data_t;

    // One decoded instruction from the front end
    typedef struct packed {
        // Target station
        rs_sel_t  rs_sel;
        // Operand already known at issue
        logic     rs1_ready;
        // Producer tag while the operand is still missing
        rob_idx_t rs1_idx;
        // Operand value, meaningful only with rs1_ready
        xlen_t    rs1_value;
        // Tag given to this instruction's result
        rob_idx_t dest_idx;
    } issue_req_t;

endpackage

//--- verilog/expipe_defines.svh
// Global sizing macros for the execution back end, included by the package and by the RTL
`ifndef EXPIPE_DEFINES_SVH
`define EXPIPE_DEFINES_SVH

// ----------------------------------------
// Data path widths
// ----------------------------------------

// Operand and result width
`define EXPIPE_XLEN 32

// ROB entry tag width
// Sets the number of in-flight tags seen on the CDB
`define EXPIPE_ROB_IDX_W 4

// ----------------------------------------
// Reservation station sizing
// ----------------------------------------

// Entries per station
// Power of two only, the FIFO pointers wrap on it
`define EXPIPE_RS_DEPTH 4

// Number of stations behind the issue arbiter
// Also the number of station inputs on the CDB arbiter
`define EXPIPE_NUM_RS 3

`endif
